// File: hdl/spi_flash_defines.svh
`ifndef SPI_FLASH_DEFINES_SVH
`define SPI_FLASH_DEFINES_SVH

// SPI timing in sys_clk cycles
`define SPI_HALF 5      // SCK half-period
`define CS_GAP   15     // Chip select high between WREN and BE
`define POLL_GAP 20     // Idle time between status reads

// Flash opcodes
`define OP_WREN  8'h06  // Write Enable
`define OP_BE    8'hC7  // Bulk Erase
`define OP_RDSR  8'h05  // Read Status Register

`endif

// File: hdl/spi_flash_pkg.sv
package spi_flash_pkg;

    typedef logic [7:0]  spi_byte_t;      // Opcode or data byte
    typedef logic [7:0]  flash_status_t;  // Bit 0 WIP, bit 1 WEL
    typedef logic [15:0] poll_cnt_t;      // Status reads per erase
    typedef logic [7:0]  half_cnt_t;      // SCK half-period and gap counts

    typedef enum logic [2:0] {
        BE_IDLE,
        BE_WREN,
        BE_GAP,
        BE_ERASE,
        BE_DONE
    } be_state_t;

    typedef enum logic [1:0] {
        POLL_IDLE,
        POLL_CMD,
        POLL_READ,
        POLL_WAIT
    } poll_state_t;

endpackage

// File: hdl/spi_byte_shifter.sv
`timescale 1ns/1ps
`include "spi_flash_defines.svh"

module spi_byte_shifter
    import spi_flash_pkg::*;
(
    input  logic       sys_clk,
    input  logic       sys_rst_n,
    input  logic       shift_start,
    input  spi_byte_t  shift_tx,
    input  logic       shift_hold_cs,
    input  logic       spi_miso,
    output logic       spi_cs_n,
    output logic       spi_sck,
    output logic       spi_mosi,
    output spi_byte_t  shift_rx,
    output logic       shift_done
);

    logic       busy;
    logic       hold_cs;
    half_cnt_t  half_cnt;
    logic [3:0] phase_cnt;      // Even phase SCK low, odd phase SCK high
    spi_byte_t  tx_sr;
    spi_byte_t  rx_sr;
    logic       half_end;
    logic       last_phase;

    assign half_end   = (half_cnt == half_cnt_t'(`SPI_HALF - 1));
    assign last_phase = (phase_cnt == 4'd15);
    assign shift_rx   = rx_sr;

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            busy       <= 1'b0;
            hold_cs    <= 1'b0;
            half_cnt   <= '0;
            phase_cnt  <= '0;
            spi_cs_n   <= 1'b1;
            spi_sck    <= 1'b0;
            spi_mosi   <= 1'b0;
            shift_done <= 1'b0;
        end else begin
            shift_done <= 1'b0;
            if (!busy) begin
                if (shift_start) begin
                    busy      <= 1'b1;
                    hold_cs   <= shift_hold_cs;
                    half_cnt  <= '0;
                    phase_cnt <= '0;
                    spi_cs_n  <= 1'b0;
                    spi_sck   <= 1'b0;
                    spi_mosi  <= shift_tx[7];   // MSB first
                end
            end else if (!half_end) begin
                half_cnt <= half_cnt + 1'b1;
            end else begin
                half_cnt  <= '0;
                phase_cnt <= phase_cnt + 1'b1;
                if (!phase_cnt[0]) begin
                    spi_sck <= 1'b1;            // Rising edge, slave samples MOSI
                end else if (last_phase) begin
                    spi_sck    <= 1'b0;
                    spi_mosi   <= 1'b0;
                    spi_cs_n   <= !hold_cs;     // Frame stays open for a follow-up byte
                    busy       <= 1'b0;
                    shift_done <= 1'b1;
                end else begin
                    spi_sck  <= 1'b0;
                    spi_mosi <= tx_sr[7];       // Next bit on falling edge
                end
            end
        end
    end

    // Shift registers
    always_ff @(posedge sys_clk) begin
        if (!busy && shift_start) begin
            tx_sr <= {shift_tx[6:0], 1'b0};
        end else if (busy && half_end && phase_cnt[0]) begin
            tx_sr <= {tx_sr[6:0], 1'b0};
        end
        if (busy && half_end && !phase_cnt[0]) begin
            rx_sr <= {rx_sr[6:0], spi_miso};    // MISO taken with SCK rise
        end
    end

endmodule

// File: hdl/spi_flash_be.sv
`timescale 1ns/1ps
`include "spi_flash_defines.svh"

module spi_flash_be
    import spi_flash_pkg::*;
(
    input  logic      sys_clk,
    input  logic      sys_rst_n,
    input  logic      erase_start,
    input  logic      shift_done,
    output logic      shift_start,
    output spi_byte_t shift_tx,
    output logic      shift_hold_cs,
    output logic      be_busy,
    output logic      check_wip
);

    be_state_t state;
    half_cnt_t gap_cnt;
    logic      gap_end;

    assign gap_end = (gap_cnt == half_cnt_t'(`CS_GAP - 1));

    // Opcode follows the state the start pulse is issued in
    assign shift_tx      = (state == BE_WREN) ? `OP_WREN : `OP_BE;
    assign shift_hold_cs = 1'b0;    // WREN and BE each close their own frame

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state       <= BE_IDLE;
            gap_cnt     <= '0;
            shift_start <= 1'b0;
            be_busy     <= 1'b0;
            check_wip   <= 1'b0;
        end else begin
            shift_start <= 1'b0;
            check_wip   <= 1'b0;
            case (state)
                BE_IDLE: begin
                    if (erase_start) begin
                        state       <= BE_WREN;
                        shift_start <= 1'b1;
                        be_busy     <= 1'b1;
                    end
                end
                BE_WREN: begin
                    if (shift_done) begin
                        state   <= BE_GAP;
                        gap_cnt <= '0;
                    end
                end
                BE_GAP: begin
                    gap_cnt <= gap_cnt + 1'b1;
                    if (gap_end) begin
                        state       <= BE_ERASE;
                        shift_start <= 1'b1;
                    end
                end
                BE_ERASE: begin
                    if (shift_done) begin
                        state     <= BE_DONE;
                        be_busy   <= 1'b0;
                        check_wip <= 1'b1;  // Hand over to the status poller
                    end
                end
                BE_DONE: begin
                    state <= BE_IDLE;
                end
                default: begin
                    state <= BE_IDLE;
                end
            endcase
        end
    end

endmodule

// File: hdl/spi_flash_wip_poll.sv
`timescale 1ns/1ps
`include "spi_flash_defines.svh"

module spi_flash_wip_poll
    import spi_flash_pkg::*;
(
    input  logic          sys_clk,
    input  logic          sys_rst_n,
    input  logic          check_wip,
    input  logic          shift_done,
    input  spi_byte_t     shift_rx,
    output logic          shift_start,
    output spi_byte_t     shift_tx,
    output logic          shift_hold_cs,
    output logic          poll_busy,
    output logic          erase_done,
    output flash_status_t final_status,
    output poll_cnt_t     poll_count
);

    localparam spi_byte_t DUMMY_BYTE = 8'hFF;

    poll_state_t   state;
    half_cnt_t     gap_cnt;
    poll_cnt_t     read_cnt;
    flash_status_t rd_status;
    logic          gap_end;

    assign rd_status = shift_rx;
    assign gap_end   = (gap_cnt == half_cnt_t'(`POLL_GAP - 1));

    // Busy from the handover cycle on, so a new erase cannot slip in
    assign poll_busy = check_wip || (state != POLL_IDLE);

    // RDSR keeps chip select low, the status byte closes the frame
    assign shift_tx      = (state == POLL_READ) ? DUMMY_BYTE : `OP_RDSR;
    assign shift_hold_cs = (state == POLL_CMD);

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state        <= POLL_IDLE;
            gap_cnt      <= '0;
            read_cnt     <= '0;
            shift_start  <= 1'b0;
            erase_done   <= 1'b0;
            final_status <= '0;
            poll_count   <= '0;
        end else begin
            shift_start <= 1'b0;
            erase_done  <= 1'b0;
            case (state)
                POLL_IDLE: begin
                    if (check_wip) begin
                        state       <= POLL_CMD;
                        shift_start <= 1'b1;
                        read_cnt    <= '0;
                    end
                end
                POLL_CMD: begin
                    if (shift_done) begin
                        state       <= POLL_READ;
                        shift_start <= 1'b1;
                    end
                end
                POLL_READ: begin
                    if (shift_done) begin
                        read_cnt <= read_cnt + 1'b1;
                        if (rd_status[0]) begin     // WIP still set
                            state   <= POLL_WAIT;
                            gap_cnt <= '0;
                        end else begin
                            state        <= POLL_IDLE;
                            erase_done   <= 1'b1;
                            final_status <= rd_status;
                            poll_count   <= read_cnt + 1'b1;
                        end
                    end
                end
                POLL_WAIT: begin
                    gap_cnt <= gap_cnt + 1'b1;
                    if (gap_end) begin
                        state       <= POLL_CMD;
                        shift_start <= 1'b1;
                    end
                end
                default: begin
                    state <= POLL_IDLE;
                end
            endcase
        end
    end

endmodule

// File: hdl/spi_flash_erase_top.sv
`timescale 1ns/1ps

module spi_flash_erase_top
    import spi_flash_pkg::*;
(
    input  logic          sys_clk,
    input  logic          sys_rst_n,
    input  logic          erase_start,
    input  logic          spi_miso,
    output logic          spi_cs_n,
    output logic          spi_sck,
    output logic          spi_mosi,
    output logic          erase_busy,
    output logic          erase_done,
    output flash_status_t final_status,
    output poll_cnt_t     poll_count
);

    logic      be_shift_start;
    spi_byte_t be_shift_tx;
    logic      be_hold_cs;
    logic      be_busy;
    logic      poll_shift_start;
    spi_byte_t poll_shift_tx;
    logic      poll_hold_cs;
    logic      poll_busy;
    logic      check_wip;
    logic      start_req;
    logic      shift_start;
    spi_byte_t shift_tx;
    logic      shift_hold_cs;
    spi_byte_t shift_rx;
    logic      shift_done;

    assign erase_busy = be_busy | poll_busy;
    assign start_req  = erase_start & ~erase_busy;  // Drop starts during an erase

    // Sequencer owns the shifter until it hands over
    assign shift_start   = be_busy ? be_shift_start : poll_shift_start;
    assign shift_tx      = be_busy ? be_shift_tx    : poll_shift_tx;
    assign shift_hold_cs = be_busy ? be_hold_cs     : poll_hold_cs;

    spi_byte_shifter shifter_i (
        .sys_clk       (sys_clk),
        .sys_rst_n     (sys_rst_n),
        .shift_start   (shift_start),
        .shift_tx      (shift_tx),
        .shift_hold_cs (shift_hold_cs),
        .spi_miso      (spi_miso),
        .spi_cs_n      (spi_cs_n),
        .spi_sck       (spi_sck),
        .spi_mosi      (spi_mosi),
        .shift_rx      (shift_rx),
        .shift_done    (shift_done)
    );

    spi_flash_be be_i (
        .sys_clk       (sys_clk),
        .sys_rst_n     (sys_rst_n),
        .erase_start   (start_req),
        .shift_done    (shift_done),
        .shift_start   (be_shift_start),
        .shift_tx      (be_shift_tx),
        .shift_hold_cs (be_hold_cs),
        .be_busy       (be_busy),
        .check_wip     (check_wip)
    );

    spi_flash_wip_poll poll_i (
        .sys_clk       (sys_clk),
        .sys_rst_n     (sys_rst_n),
        .check_wip     (check_wip),
        .shift_done    (shift_done),
        .shift_rx      (shift_rx),
        .shift_start   (poll_shift_start),
        .shift_tx      (poll_shift_tx),
        .shift_hold_cs (poll_hold_cs),
        .poll_busy     (poll_busy),
        .erase_done    (erase_done),
        .final_status  (final_status),
        .poll_count    (poll_count)
    );

endmodule

// File: sim/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int CLK_PERIOD = 100,
    parameter int RST_CYCLES = 4
) (
    output logic sys_clk,
    output logic sys_rst_n
);

    initial begin
        sys_clk = 1'b0;
        forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
    end

    initial begin
        sys_rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge sys_clk);
        @(negedge sys_clk);
        sys_rst_n = 1'b1;   // Released away from the active edge
    end

endmodule

// File: sim/spi_flash_model.sv
`timescale 1ns/1ps
`include "spi_flash_defines.svh"

module spi_flash_model
    import spi_flash_pkg::*;
(
    input  logic      sys_clk,
    input  poll_cnt_t busy_reads,
    input  logic      spi_cs_n,
    input  logic      spi_sck,
    input  logic      spi_mosi,
    output logic      spi_miso,
    output logic      op_valid,
    output spi_byte_t op_code
);

    logic       sck_q = 1'b0;
    logic [3:0] bit_cnt = '0;       // Bits seen in the current frame
    spi_byte_t  in_sr = '0;
    spi_byte_t  out_sr = '0;
    logic       wel = 1'b0;
    logic       wip = 1'b0;
    poll_cnt_t  busy_left = '0;
    spi_byte_t  mosi_byte;

    initial begin
        spi_miso = 1'b0;
        op_valid = 1'b0;
        op_code  = '0;
    end

    assign mosi_byte = {in_sr[6:0], spi_mosi};

    // Oversamples the SPI pins on the falling system clock
    always @(negedge sys_clk) begin
        op_valid <= 1'b0;
        sck_q    <= spi_sck;
        if (spi_cs_n) begin
            bit_cnt  <= '0;
            out_sr   <= '0;
            spi_miso <= 1'b0;
        end else if (spi_sck && !sck_q) begin
            in_sr <= mosi_byte;
            if (bit_cnt != 4'd15) begin
                bit_cnt <= bit_cnt + 4'd1;
            end
            if (bit_cnt == 4'd7) begin      // First byte of a frame is the opcode
                op_valid <= 1'b1;
                op_code  <= mosi_byte;
                case (mosi_byte)
                    `OP_WREN: wel <= 1'b1;
                    `OP_BE: begin
                        if (wel && busy_reads == 16'd0) begin
                            wel <= 1'b0;
                        end else if (wel) begin
                            wip       <= 1'b1;
                            busy_left <= busy_reads;
                        end
                    end
                    `OP_RDSR: begin
                        out_sr <= {6'b0, wel, wip};
                        if (wip) begin
                            busy_left <= busy_left - 16'd1;
                            if (busy_left == 16'd1) begin
                                wip <= 1'b0;    // Erase finished after this read
                                wel <= 1'b0;
                            end
                        end
                    end
                    default: ;
                endcase
            end
        end else if (!spi_sck && sck_q) begin
            spi_miso <= out_sr[7];
            out_sr   <= {out_sr[6:0], 1'b0};
        end
    end

endmodule

// File: sim/spi_flash_erase_sva.sv
`timescale 1ns/1ps

module spi_flash_erase_sva (
    input logic sys_clk,
    input logic sys_rst_n,
    input logic erase_start,
    input logic spi_cs_n,
    input logic spi_sck,
    input logic erase_busy,
    input logic erase_done,
    input logic check_wip
);

    logic started;
    int   fail_cnt = 0;

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            started <= 1'b0;
        end else if (erase_start) begin
            started <= 1'b1;
        end
    end

    sck_low_when_deselected: assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n) spi_cs_n |-> !spi_sck
    ) else begin
        $error("SCK high while chip select is inactive");
        fail_cnt++;
    end

    done_apart_from_handover: assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n) !(erase_done && check_wip)
    ) else begin
        $error("erase_done and check_wip high in the same cycle");
        fail_cnt++;
    end

    no_busy_before_start: assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n) !started |-> !erase_busy
    ) else begin
        $error("erase_busy high before any erase_start");
        fail_cnt++;
    end

endmodule

bind spi_flash_erase_top spi_flash_erase_sva sva_i (
    .sys_clk     (sys_clk),
    .sys_rst_n   (sys_rst_n),
    .erase_start (erase_start),
    .spi_cs_n    (spi_cs_n),
    .spi_sck     (spi_sck),
    .erase_busy  (erase_busy),
    .erase_done  (erase_done),
    .check_wip   (check_wip)
);

// File: sim/tb_spi_flash_erase.sv
`timescale 1ns/1ps
`include "spi_flash_defines.svh"

module tb_spi_flash_erase
    import spi_flash_pkg::*;
();

    localparam int NUM_TESTS     = 4;
    localparam int IDLE_CYCLES   = 50;
    localparam int SETTLE_CYCLES = 200;    // Room for a stray frame to show up

    typedef struct packed {
        poll_cnt_t busy_reads;
        logic      mid_start;       // Second start while the erase runs
    } test_row_t;

    logic          sys_clk;
    logic          sys_rst_n;
    logic          erase_start;
    logic          spi_miso;
    logic          spi_cs_n;
    logic          spi_sck;
    logic          spi_mosi;
    logic          erase_busy;
    logic          erase_done;
    flash_status_t final_status;
    poll_cnt_t     poll_count;
    poll_cnt_t     busy_reads;
    logic          op_valid;
    spi_byte_t     op_code;

    test_row_t     test_table [NUM_TESTS];
    logic          table_loaded = 1'b0;
    spi_byte_t     op_q [$];
    int            done_cnt = 0;
    int            error_cnt = 0;
    int            test_errs = 0;
    int            test_cnt = 0;
    int            pass_cnt = 0;
    integer        seed;

    tb_clk_gen clk_gen_i (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n)
    );

    spi_flash_erase_top dut_i (
        .sys_clk      (sys_clk),
        .sys_rst_n    (sys_rst_n),
        .erase_start  (erase_start),
        .spi_miso     (spi_miso),
        .spi_cs_n     (spi_cs_n),
        .spi_sck      (spi_sck),
        .spi_mosi     (spi_mosi),
        .erase_busy   (erase_busy),
        .erase_done   (erase_done),
        .final_status (final_status),
        .poll_count   (poll_count)
    );

    spi_flash_model flash_i (
        .sys_clk    (sys_clk),
        .busy_reads (busy_reads),
        .spi_cs_n   (spi_cs_n),
        .spi_sck    (spi_sck),
        .spi_mosi   (spi_mosi),
        .spi_miso   (spi_miso),
        .op_valid   (op_valid),
        .op_code    (op_code)
    );

    always @(posedge sys_clk) begin
        if (op_valid) begin
            op_q.push_back(op_code);
        end
        if (erase_done) begin
            done_cnt++;
        end
    end

    function automatic int row_cycles(input poll_cnt_t busy);
        return (int'(busy) + 1) * (32 * `SPI_HALF + `POLL_GAP + 4) + 80 * `SPI_HALF;
    endfunction

    task automatic load_table();
        test_table[0] = '{busy_reads: 16'd0, mid_start: 1'b0};
        test_table[1] = '{busy_reads: 16'd1, mid_start: 1'b1};
        test_table[2] = '{busy_reads: 16'd3, mid_start: 1'b0};
        test_table[3] = '{busy_reads: 16'd7, mid_start: 1'b1};
    endtask

    task automatic note_failure(input string what);
        $display("%s", what);
        error_cnt++;
        test_errs++;
    endtask

    task automatic check_byte(input string name, input spi_byte_t exp, input spi_byte_t got);
        if (got !== exp) begin
            $display("error: %s expected %h got %h", name, exp, got);
            error_cnt++;
            test_errs++;
        end
    endtask

    task automatic check_status(input string name, input flash_status_t exp,
                                input flash_status_t got);
        if (got !== exp) begin
            $display("error: %s expected %h got %h", name, exp, got);
            error_cnt++;
            test_errs++;
        end
    endtask

    task automatic check_count(input string name, input poll_cnt_t exp, input poll_cnt_t got);
        if (got !== exp) begin
            $display("error: %s expected %h got %h", name, exp, got);
            error_cnt++;
            test_errs++;
        end
    endtask

    task automatic finish_test(input string label);
        test_cnt++;
        if (test_errs == 0) begin
            pass_cnt++;
        end
        $display("test %0d %s : %s", test_cnt, label, (test_errs == 0) ? "pass" : "fail");
    endtask

    // Quiet bus and outputs before any erase is requested
    task automatic watch_idle(input int cycles);
        int moves;
        moves = 0;
        test_errs = 0;
        repeat (cycles) begin
            @(negedge sys_clk);
            if (spi_cs_n !== 1'b1 || spi_sck !== 1'b0 || spi_mosi !== 1'b0) begin
                moves++;
            end
            if (erase_done !== 1'b0 || erase_busy !== 1'b0) begin
                moves++;
            end
        end
        if (moves != 0) begin
            note_failure("SPI pins or erase outputs moved before the first start");
        end
        check_status("final_status", 8'h00, final_status);
        check_count("poll_count", 16'h0000, poll_count);
        finish_test("idle after reset");
    endtask

    task automatic run_erase(input int idx);
        test_row_t row;
        int        limit;
        int        cycles;
        int        done_before;
        int        exp_reads;
        int        delay;
        int        k;
        spi_byte_t exp_op;
        row = test_table[idx];
        limit = row_cycles(row.busy_reads);
        exp_reads = int'(row.busy_reads) + 1;
        test_errs = 0;
        op_q.delete();
        done_before = done_cnt;
        @(negedge sys_clk);
        busy_reads  = row.busy_reads;
        erase_start = 1'b1;
        @(negedge sys_clk);
        erase_start = 1'b0;
        if (row.mid_start) begin
            // Past WREN, gap and BE, so the sequencer is idle again
            delay = 40 * `SPI_HALF + ($unsigned($random(seed)) % (32 * `SPI_HALF));
            repeat (delay) @(negedge sys_clk);
            if (erase_busy !== 1'b1) begin
                note_failure("erase_busy dropped while the erase was still running");
            end
            erase_start = 1'b1;
            @(negedge sys_clk);
            erase_start = 1'b0;
        end
        cycles = 0;
        while (done_cnt == done_before && cycles < limit) begin
            @(negedge sys_clk);
            cycles++;
        end
        if (done_cnt == done_before) begin
            note_failure("erase_done never arrived within the expected time");
        end else begin
            check_status("final_status", 8'h00, final_status);
            check_count("poll_count", poll_cnt_t'(exp_reads), poll_count);
        end
        repeat (SETTLE_CYCLES) @(negedge sys_clk);
        if (done_cnt > done_before + 1) begin
            note_failure("erase_done pulsed more than once for one erase");
        end
        if (erase_busy !== 1'b0) begin
            note_failure("erase_busy still high after the erase finished");
        end
        if (op_q.size() != exp_reads + 2) begin
            note_failure("flash model decoded the wrong number of opcodes");
        end
        for (k = 0; k < op_q.size(); k++) begin
            exp_op = (k == 0) ? `OP_WREN : (k == 1) ? `OP_BE : `OP_RDSR;
            check_byte("opcode", exp_op, op_q[k]);
        end
        finish_test($sformatf("busy_reads=%0d mid_start=%0d", row.busy_reads, row.mid_start));
    endtask

    initial begin
        int i;
        erase_start = 1'b0;
        busy_reads  = '0;
        seed = 92;
        load_table();
        table_loaded = 1'b1;
        wait (sys_rst_n === 1'b1);
        watch_idle(IDLE_CYCLES);
        for (i = 0; i < NUM_TESTS; i++) begin
            run_erase(i);
        end
        if (dut_i.sva_i.fail_cnt != 0) begin
            note_failure("bound assertions failed during the run");
        end
        $display("tests=%0d passed=%0d failed=%0d errors=%0d",
                 test_cnt, pass_cnt, test_cnt - pass_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Watchdog sized from the table
    initial begin
        int budget;
        int w;
        wait (table_loaded === 1'b1);
        budget = 0;
        for (w = 0; w < NUM_TESTS; w++) begin
            budget += row_cycles(test_table[w].busy_reads);
        end
        budget = 2 * budget;
        repeat (budget) @(posedge sys_clk);
        $display("timeout: run did not finish within %0d clock cycles", budget);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: spi_flash_erase.f
+incdir+hdl
hdl/spi_flash_pkg.sv
hdl/spi_byte_shifter.sv
hdl/spi_flash_be.sv
hdl/spi_flash_wip_poll.sv
hdl/spi_flash_erase_top.sv
sim/tb_clk_gen.sv
sim/spi_flash_model.sv
sim/spi_flash_erase_sva.sv
sim/tb_spi_flash_erase.sv

// File: Makefile
# Verilator build and run for the SPI flash bulk-erase controller

VERILATOR ?= verilator
TOP       ?= tb_spi_flash_erase
FILELIST  ?= spi_flash_erase.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SIM_BIN  = $(OBJ_DIR)/V$(TOP)
SOURCES  = $(wildcard hdl/*.sv hdl/*.svh sim/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST FAILED" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
